/* cpu_core.f */
rtl/cpu_isa_pkg.sv
rtl/cpu_core_pkg.sv
rtl/cpu_control.sv
rtl/cpu_pc_unit.sv
rtl/cpu_regfile.sv
rtl/cpu_alu.sv
rtl/cpu_agu.sv
rtl/cpu_core.sv
sim/cpu_tb_memory.sv
sim/cpu_core_tb.sv

/* sim/cpu_core_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module cpu_core_tb;
	import cpu_isa_pkg::*;
	import cpu_core_pkg::*;

	localparam logic [15:0] RESET_VECTOR = 16'h4000;
	localparam int TRAP_TIMEOUT = 500;

	logic clk;
	logic reset;
	logic [15:0] iread_addr;
	instr_u iread_data;
	logic [15:0] dread_addr;
	logic [15:0] dread_data;
	dwrite_t dwrite;
	logic trap;

	integer seed;
	logic [15:0] asm_pc;
	// architectural state as the program should leave it
	logic [7:0] model_xl;
	logic model_c;
	logic model_z;
	dwrite_t expected[$];
	dwrite_t captured[$];
	logic [15:0] expected_reads[$];
	logic [15:0] captured_reads[$];

	cpu_tb_memory mem (
		.clk(clk),
		.iread_addr(iread_addr),
		.iread_data(iread_data),
		.dread_addr(dread_addr),
		.dread_data(dread_data),
		.dwrite(dwrite)
	);

	cpu_core dut (
		.clk(clk),
		.reset(reset),
		.iread_addr(iread_addr),
		.iread_data(iread_data),
		.dread_addr(dread_addr),
		.dread_data(dread_data),
		.dwrite(dwrite),
		.trap(trap)
	);

	initial
	begin
		clk = 1'b0;
		forever
			#10 clk = ~clk;
	end

	task automatic stop_with_failure;
		$display("Testbench failed");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_equal(input string name, input logic [15:0] got,
		input logic [15:0] exp);
		assert (got === exp)
		else
		begin
			$display("** Error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
			stop_with_failure();
		end
	endtask

	// writes are sampled mid-cycle before they land
	always @(negedge clk)
	begin
		if (!reset && trap)
			check_equal("dwrite.en while trap", {14'd0, dwrite.en}, 16'd0);
		else if (!reset && dwrite.en != 2'b00)
			captured.push_back(dwrite);
	end

	// a nonzero read address marks a load in its fetch cycle
	always @(negedge clk)
	begin
		if (!reset && dread_addr != 16'h0000)
			captured_reads.push_back(dread_addr);
	end

	task automatic put_byte(input logic [7:0] b);
		mem.rom[asm_pc] = b;
		asm_pc = asm_pc + 16'd1;
	endtask

	task automatic put_op(input opcode_t op);
		put_byte(op);
	endtask

	task automatic put_op8(input opcode_t op, input logic [7:0] imm);
		put_byte(op);
		put_byte(imm);
	endtask

	task automatic put_op16(input opcode_t op, input logic [15:0] imm);
		put_byte(op);
		put_byte(imm[7:0]);
		put_byte(imm[15:8]);
	endtask

	task automatic expect_write(input logic [15:0] addr, input logic [15:0] data,
		input logic [1:0] en);
		dwrite_t w;
		w.addr = addr;
		w.data = data;
		w.en = en;
		expected.push_back(w);
	endtask

	task automatic begin_program;
		// opcodes 80 to ff are undefined and run as NOP
		for (int a = 0; a < 65536; a++)
			mem.rom[a] = {1'b1, a[14:8] ^ a[6:0] ^ {6'd0, a[15] ^ a[7]}};
		asm_pc = RESET_VECTOR;
		expected.delete();
		expected_reads.delete();
		model_xl = 8'h00;
		model_c = 1'b0;
		model_z = 1'b0;
	endtask

	task automatic asm_load_xl(input logic [7:0] v);
		put_op8(OP_LD_XL_IMM, v);
		model_xl = v;
	endtask

	task automatic asm_store_xl(input logic [15:0] addr);
		put_op16(OP_LD_DIR_XL, addr);
		expect_write(addr, {8'h00, model_xl}, 2'b01);
	endtask

	task automatic asm_alu8(input opcode_t op, input logic [7:0] imm);
		int a;
		int b;
		int r;
		a = model_xl;
		b = imm;
		put_op8(op, imm);
		case (op)
			OP_ADD_XL_IMM:
			begin
				r = a + b;
				model_c = (r > 255);
			end
			OP_SUB_XL_IMM:
			begin
				r = a - b;
				// c set means no borrow
				model_c = (a >= b);
			end
			OP_AND_XL_IMM: r = a & b;
			OP_OR_XL_IMM: r = a | b;
			default: r = a ^ b;
		endcase
		model_xl = r[7:0];
		model_z = (model_xl == 8'h00);
	endtask

	// branch over one store that shows up only when not taken
	task automatic asm_branch(input opcode_t op, input logic [15:0] skip_addr);
		logic taken;
		case (op)
			OP_JRZ_D: taken = model_z;
			OP_JRNZ_D: taken = !model_z;
			OP_JRC_D: taken = model_c;
			default: taken = !model_c;
		endcase
		put_op8(op, 8'd5);
		put_op16(OP_LD_DIR_XL, skip_addr);
		if (!taken)
			expect_write(skip_addr, {8'h00, model_xl}, 2'b01);
	endtask

	task automatic apply_reset;
		@(posedge clk);
		#1 reset = 1'b1;
		for (int i = 0; i < 4; i++)
		begin
			@(negedge clk);
			check_equal("iread_addr", iread_addr, RESET_VECTOR);
			// the executing word is cleared by the first reset edge
			if (i > 0)
			begin
				check_equal("dwrite.en", {14'd0, dwrite.en}, 16'd0);
				check_equal("trap", {15'd0, trap}, 16'd0);
			end
			@(posedge clk);
		end
		#1 reset = 1'b0;
		captured.delete();
		captured_reads.delete();
	endtask

	task automatic wait_trap(output int cycles);
		cycles = 0;
		@(negedge clk);
		while (trap !== 1'b1)
		begin
			if (cycles == TRAP_TIMEOUT)
			begin
				$display("trap did not rise within %0d cycles after reset", TRAP_TIMEOUT);
				stop_with_failure();
			end
			cycles++;
			@(negedge clk);
		end
	endtask

	task automatic run_program(output int cycles);
		apply_reset();
		wait_trap(cycles);
	endtask

	task automatic check_writes;
		dwrite_t got;
		dwrite_t exp;
		check_equal("number of writes", 16'(captured.size()), 16'(expected.size()));
		foreach (expected[i])
		begin
			got = captured[i];
			exp = expected[i];
			check_equal($sformatf("write %0d dwrite.addr", i), got.addr, exp.addr);
			check_equal($sformatf("write %0d dwrite.en", i), {14'd0, got.en}, {14'd0, exp.en});
			if (exp.en[0])
				check_equal($sformatf("write %0d dwrite.data[7:0]", i),
					{8'h00, got.data[7:0]}, {8'h00, exp.data[7:0]});
			if (exp.en[1])
				check_equal($sformatf("write %0d dwrite.data[15:8]", i),
					{8'h00, got.data[15:8]}, {8'h00, exp.data[15:8]});
		end
	endtask

	task automatic check_reads;
		check_equal("number of reads", 16'(captured_reads.size()),
			16'(expected_reads.size()));
		foreach (expected_reads[i])
			check_equal($sformatf("read %0d dread_addr", i), captured_reads[i],
				expected_reads[i]);
	endtask

	task automatic test_alu8;
		opcode_t ops [5] = '{OP_ADD_XL_IMM, OP_SUB_XL_IMM, OP_AND_XL_IMM,
			OP_OR_XL_IMM, OP_XOR_XL_IMM};
		logic [7:0] imm;
		int cycles;
		begin_program();
		imm = $random(seed);
		asm_load_xl(imm);
		asm_store_xl(16'h1000);
		for (int round = 0; round < 4; round++)
		begin
			for (int i = 0; i < 5; i++)
			begin
				imm = $random(seed);
				asm_alu8(ops[i], imm);
				asm_store_xl(16'h1001 + 16'(round * 8 + i));
			end
		end
		put_op(OP_TRAP);
		run_program(cycles);
		check_writes();
	endtask

	task automatic test_reset;
		int cycles;
		begin_program();
		// x must read back as zero after reset
		asm_store_xl(16'h7000);
		asm_load_xl(8'h96);
		asm_store_xl(16'h7001);
		put_op(OP_TRAP);
		apply_reset();
		@(negedge clk);
		check_equal("iread_addr after reset", iread_addr, RESET_VECTOR + 16'd3);
		wait_trap(cycles);
		check_writes();
	endtask

	task automatic test_wide;
		logic [15:0] y_val;
		logic [15:0] y_add;
		logic [15:0] sum;
		logic [15:0] off;
		logic [7:0] v;
		int cycles;
		y_val = $random(seed);
		y_add = $random(seed);
		sum = y_val + y_add;
		v = $random(seed);
		off = 16'h2100 + 16'($random(seed) & 8'hff) - sum;
		begin_program();
		put_op16(OP_LDW_Y_IMM, y_val);
		put_op16(OP_ADDW_Y_IMM, y_add);
		put_op16(OP_LDW_DIR_Y, 16'h2000);
		expect_write(16'h2000, sum, 2'b11);
		put_op(OP_LDW_Z_Y);
		asm_load_xl(v);
		put_op16(OP_LD_ZREL_XL, off);
		expect_write(sum + off, {8'h00, v}, 2'b01);
		put_op(OP_TRAP);
		run_program(cycles);
		check_writes();
		check_equal("ram[2000]", {8'h00, mem.ram[16'h2000]}, {8'h00, sum[7:0]});
		check_equal("ram[2001]", {8'h00, mem.ram[16'h2001]}, {8'h00, sum[15:8]});
	endtask

	task automatic test_loads;
		int cycles;
		begin_program();
		put_op16(OP_LDW_Y_IMM, 16'h3000);
		put_op(OP_LDW_Z_Y);
		// a stale read would return the old byte
		asm_load_xl(8'hc3);
		asm_store_xl(16'h3010);
		asm_load_xl(8'h3c);
		asm_store_xl(16'h3010);
		put_op16(OP_LD_XL_DIR, 16'h3010);
		expected_reads.push_back(16'h3010);
		model_xl = 8'h3c;
		asm_store_xl(16'h3100);
		asm_load_xl(8'ha5);
		asm_store_xl(16'h3020);
		asm_load_xl(8'h5a);
		asm_store_xl(16'h3020);
		put_op16(OP_LD_XL_ZREL, 16'h0020);
		expected_reads.push_back(16'h3000 + 16'h0020);
		model_xl = 8'h5a;
		asm_store_xl(16'h3101);
		// z changes in the cycle the z-relative read goes out
		asm_load_xl(8'h00);
		put_op16(OP_LDW_Y_IMM, 16'h2f00);
		put_op(OP_LDW_Z_Y);
		put_op16(OP_LD_XL_ZREL, 16'h0110);
		expected_reads.push_back(16'h2f00 + 16'h0110);
		model_xl = 8'h3c;
		asm_store_xl(16'h3102);
		put_op(OP_TRAP);
		run_program(cycles);
		check_writes();
		check_reads();
	endtask

	task automatic test_control;
		opcode_t alu_ops [8] = '{OP_SUB_XL_IMM, OP_ADD_XL_IMM, OP_SUB_XL_IMM, OP_ADD_XL_IMM,
			OP_SUB_XL_IMM, OP_ADD_XL_IMM, OP_SUB_XL_IMM, OP_ADD_XL_IMM};
		logic [7:0] a_vals [8] = '{8'h05, 8'hf0, 8'h05, 8'hf0, 8'h03, 8'h10, 8'h03, 8'h10};
		logic [7:0] b_vals [8] = '{8'h05, 8'h10, 8'h05, 8'h20, 8'h05, 8'h20, 8'h05, 8'h20};
		opcode_t branches [8] = '{OP_JRZ_D, OP_JRNZ_D, OP_JRC_D, OP_JRNC_D,
			OP_JRZ_D, OP_JRNZ_D, OP_JRC_D, OP_JRNC_D};
		int cycles;
		begin_program();
		asm_load_xl(8'h77);
		put_op16(OP_JP_IMM, asm_pc + 16'd6);
		put_op16(OP_LD_DIR_XL, 16'h5000);
		asm_store_xl(16'h5001);
		put_op8(OP_JR_D, 8'd5);
		put_op16(OP_LD_DIR_XL, 16'h5002);
		asm_store_xl(16'h5003);
		// forward over a block and then back into it
		put_op8(OP_JR_D, 8'd7);
		put_op16(OP_LD_DIR_XL, 16'h5004);
		put_op8(OP_JR_D, 8'd7);
		put_op16(OP_LD_DIR_XL, 16'h5005);
		put_op8(OP_JR_D, 8'hf8);
		expect_write(16'h5005, 16'h0077, 2'b01);
		expect_write(16'h5004, 16'h0077, 2'b01);
		for (int i = 0; i < 8; i++)
		begin
			asm_load_xl(a_vals[i]);
			asm_alu8(alu_ops[i], b_vals[i]);
			asm_branch(branches[i], 16'h6000 + 16'(2 * i));
			asm_store_xl(16'h6001 + 16'(2 * i));
		end
		put_op(OP_TRAP);
		run_program(cycles);
		check_writes();
	endtask

	task automatic test_trap;
		int cycles;
		begin_program();
		// trap byte as an operand and as a skipped opcode
		asm_load_xl(OP_TRAP);
		put_op8(OP_JR_D, 8'd3);
		put_op(OP_TRAP);
		put_op(OP_NOP);
		asm_store_xl(16'h7100);
		put_op(OP_TRAP);
		run_program(cycles);
		// four instructions ahead of it plus the fill
		check_equal("cycle of trap rise", 16'(cycles), 16'd5);
		@(negedge clk);
		check_equal("trap one cycle later", {15'd0, trap}, 16'd0);
		check_writes();
	endtask

	initial
	begin
		seed = 32'heb2f_c39d;
		reset = 1'b1;
		test_alu8();
		test_reset();
		test_wide();
		test_loads();
		test_control();
		test_trap();
		$display("Testbench passed");
		$finish;
	end

endmodule

`default_nettype wire

/* sim/cpu_tb_memory.sv */
`timescale 1ns/1ns
`default_nettype none

module cpu_tb_memory (
	input logic clk,
	input logic [15:0] iread_addr,
	output cpu_isa_pkg::instr_u iread_data,
	input logic [15:0] dread_addr,
	output logic [15:0] dread_data,
	input cpu_core_pkg::dwrite_t dwrite
);
	logic [7:0] rom [0:65535];
	logic [7:0] ram [0:65535];

	// byte seen by a read issued in the same cycle as a write
	function automatic logic [7:0] read_byte(input logic [15:0] addr);
		if (dwrite.en[0] && dwrite.addr == addr)
			return dwrite.data[7:0];
		if (dwrite.en[1] && dwrite.addr + 16'd1 == addr)
			return dwrite.data[15:8];
		return ram[addr];
	endfunction

	initial
	begin
		iread_data = '0;
		dread_data = 16'h0000;
		for (int a = 0; a < 65536; a++)
			ram[a] = a[15:8] ^ a[7:0];
	end

	// one-cycle read latency on both ports
	always @(posedge clk)
	begin
		iread_data <= {rom[iread_addr + 16'd2], rom[iread_addr + 16'd1], rom[iread_addr]};
		dread_data <= {read_byte(dread_addr + 16'd1), read_byte(dread_addr)};
		if (dwrite.en[0])
			ram[dwrite.addr] <= dwrite.data[7:0];
		if (dwrite.en[1])
			ram[dwrite.addr + 16'd1] <= dwrite.data[15:8];
	end

endmodule

`default_nettype wire

/* rtl/cpu_core.sv */
`timescale 1ns/1ns
`default_nettype none

module cpu_core #(
	parameter logic [15:0] RESET_PC = cpu_core_pkg::RESET_PC_DEFAULT
) (
	input logic clk,
	input logic reset,
	output logic [15:0] iread_addr,
	input cpu_isa_pkg::instr_u iread_data,
	output logic [15:0] dread_addr,
	input logic [15:0] dread_data,
	output cpu_core_pkg::dwrite_t dwrite,
	output logic trap
);
	import cpu_isa_pkg::*;
	import cpu_core_pkg::*;

	fetch_ctrl_t fetch;
	exec_ctrl_t exec;
	instr_u inst;
	logic [15:0] x, y, z;
	logic [15:0] next_z;
	logic [15:0] result;
	flags_t next_flags;

	cpu_control control (
		.clk(clk),
		.reset(reset),
		.iread_data(iread_data),
		.fetch(fetch),
		.exec(exec),
		.inst(inst),
		.trap(trap)
	);

	cpu_pc_unit #(
		.RESET_PC(RESET_PC)
	) pc_unit (
		.clk(clk),
		.reset(reset),
		.fetch(fetch),
		.iread_data(iread_data),
		.next_flags(next_flags),
		.iread_addr(iread_addr)
	);

	cpu_regfile regfile (
		.clk(clk),
		.reset(reset),
		.exec(exec),
		.result(result),
		.x(x),
		.y(y),
		.z(z),
		.next_z(next_z)
	);

	cpu_alu alu (
		.clk(clk),
		.reset(reset),
		.exec(exec),
		.inst(inst),
		.x(x),
		.y(y),
		.dread_data(dread_data),
		.result(result),
		.next_flags(next_flags)
	);

	cpu_agu agu (
		.fetch(fetch),
		.iread_data(iread_data),
		.exec(exec),
		.inst(inst),
		.z(z),
		.next_z(next_z),
		.result(result),
		.dread_addr(dread_addr),
		.dwrite(dwrite)
	);

endmodule

`default_nettype wire

/* rtl/cpu_agu.sv */
`timescale 1ns/1ns
`default_nettype none

module cpu_agu (
	input cpu_core_pkg::fetch_ctrl_t fetch,
	input cpu_isa_pkg::instr_u iread_data,
	input cpu_core_pkg::exec_ctrl_t exec,
	input cpu_isa_pkg::instr_u inst,
	input logic [15:0] z,
	input logic [15:0] next_z,
	input logic [15:0] result,
	output logic [15:0] dread_addr,
	output cpu_core_pkg::dwrite_t dwrite
);
	import cpu_core_pkg::*;

	// read goes out in the fetch cycle, so z may be changing under it
	always_comb
	begin
		case (fetch.read_mode)
			MEM_DIR: dread_addr = iread_data.wide.imm16;
			MEM_ZREL: dread_addr = next_z + iread_data.wide.imm16;
			default: dread_addr = 16'h0000;
		endcase
	end

	// write lands at the end of the execute cycle
	always_comb
	begin
		case (exec.write_mode)
			MEM_DIR: dwrite.addr = inst.wide.imm16;
			MEM_ZREL: dwrite.addr = z + inst.wide.imm16;
			default: dwrite.addr = 16'h0000;
		endcase
		dwrite.data = result;
		dwrite.en = exec.write_en;
	end

endmodule

`default_nettype wire

/* rtl/cpu_alu.sv */
`timescale 1ns/1ns
`default_nettype none

module cpu_alu (
	input logic clk,
	input logic reset,
	input cpu_core_pkg::exec_ctrl_t exec,
	input cpu_isa_pkg::instr_u inst,
	input logic [15:0] x,
	input logic [15:0] y,
	input logic [15:0] dread_data,
	output logic [15:0] result,
	output cpu_core_pkg::flags_t next_flags
);
	import cpu_isa_pkg::*;
	import cpu_core_pkg::*;

	logic wide;
	logic [15:0] a;
	logic [15:0] b;
	logic carry;
	flags_t flags;

	assign wide = (exec.alu_op == PASS16) || (exec.alu_op == ADD16);
	assign b = wide ? inst.wide.imm16 : {8'h00, inst.narrow.imm8};

	always_comb
	begin
		case (exec.a_src)
			A_XL: a = {8'h00, x[7:0]};
			A_Y: a = y;
			A_MEM: a = dread_data;
			default: a = b;
		endcase
	end

	// 8-bit results leave the upper byte zero
	always_comb
	begin
		carry = 1'b0;
		result = 16'h0000;
		case (exec.alu_op)
			PASS8: result[7:0] = a[7:0];
			ADD8: {carry, result[7:0]} = {1'b0, a[7:0]} + {1'b0, b[7:0]};
			// carry set means no borrow
			SUB8: {carry, result[7:0]} = {1'b0, a[7:0]} + {1'b0, ~b[7:0]} + 9'd1;
			AND8: result[7:0] = a[7:0] & b[7:0];
			OR8: result[7:0] = a[7:0] | b[7:0];
			XOR8: result[7:0] = a[7:0] ^ b[7:0];
			PASS16: result = a;
			ADD16: {carry, result} = {1'b0, a} + {1'b0, b};
		endcase
	end

	always_comb
	begin
		next_flags = flags;
		if (exec.flag_mask.c)
			next_flags.c = carry;
		if (exec.flag_mask.z)
			next_flags.z = wide ? (result == 16'h0000) : (result[7:0] == 8'h00);
		if (exec.flag_mask.n)
			next_flags.n = wide ? result[15] : result[7];
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			flags <= '0;
		else
			flags <= next_flags;
	end

	assert property (@(posedge clk) disable iff (reset)
		exec.alu_op inside {PASS8, ADD8, SUB8, AND8, OR8, XOR8, PASS16, ADD16});

endmodule

`default_nettype wire

/* rtl/cpu_regfile.sv */
`timescale 1ns/1ns
`default_nettype none

module cpu_regfile (
	input logic clk,
	input logic reset,
	input cpu_core_pkg::exec_ctrl_t exec,
	input logic [15:0] result,
	output logic [15:0] x,
	output logic [15:0] y,
	output logic [15:0] z,
	output logic [15:0] next_z
);
	import cpu_isa_pkg::*;

	logic [15:0] next_x;
	logic [15:0] next_y;

	function automatic logic [15:0] merge_bytes(
		input logic [15:0] old,
		input logic [1:0] en,
		input logic [15:0] data
	);
		return {en[1] ? data[15:8] : old[15:8], en[0] ? data[7:0] : old[7:0]};
	endfunction

	// values after the coming edge, next_z feeds z-relative reads
	assign next_x = (exec.reg_sel == REG_X) ? merge_bytes(x, exec.reg_en, result) : x;
	assign next_y = (exec.reg_sel == REG_Y) ? merge_bytes(y, exec.reg_en, result) : y;
	assign next_z = (exec.reg_sel == REG_Z) ? merge_bytes(z, exec.reg_en, result) : z;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			x <= 16'h0000;
			y <= 16'h0000;
			z <= 16'h0000;
		end
		else
		begin
			x <= next_x;
			y <= next_y;
			z <= next_z;
		end
	end

	assert property (@(posedge clk) disable iff (reset)
		exec.reg_en != 2'b00 |-> exec.reg_sel inside {REG_X, REG_Y, REG_Z});

endmodule

`default_nettype wire

/* rtl/cpu_pc_unit.sv */
`timescale 1ns/1ns
`default_nettype none

module cpu_pc_unit #(
	parameter logic [15:0] RESET_PC = cpu_core_pkg::RESET_PC_DEFAULT
) (
	input logic clk,
	input logic reset,
	input cpu_core_pkg::fetch_ctrl_t fetch,
	input cpu_isa_pkg::instr_u iread_data,
	input cpu_core_pkg::flags_t next_flags,
	output logic [15:0] iread_addr
);
	import cpu_core_pkg::*;

	// address of the word now on iread_data
	logic [15:0] pc;
	logic [15:0] seq_pc;
	logic [15:0] rel_pc;
	logic [15:0] next_pc;

	assign seq_pc = pc + {14'd0, fetch.length};
	assign rel_pc = pc + {{8{iread_data.narrow.imm8[7]}}, iread_data.narrow.imm8};

	// conditions see the flags of the instruction executing now
	always_comb
	begin
		case (fetch.jump)
			JMP_ABS: next_pc = iread_data.wide.imm16;
			JMP_REL: next_pc = rel_pc;
			JMP_REL_Z: next_pc = next_flags.z ? rel_pc : seq_pc;
			JMP_REL_NZ: next_pc = next_flags.z ? seq_pc : rel_pc;
			JMP_REL_C: next_pc = next_flags.c ? rel_pc : seq_pc;
			JMP_REL_NC: next_pc = next_flags.c ? seq_pc : rel_pc;
			default: next_pc = seq_pc;
		endcase
	end

	assign iread_addr = reset ? RESET_PC : next_pc;

	always_ff @(posedge clk)
	begin
		if (reset)
			pc <= RESET_PC;
		else
			pc <= iread_addr;
	end

	// the vector presented during reset is the first word fetched
	assert property (@(posedge clk) reset |=> pc == RESET_PC);

endmodule

`default_nettype wire

/* rtl/cpu_control.sv */
`timescale 1ns/1ns
`default_nettype none

module cpu_control (
	input logic clk,
	input logic reset,
	input cpu_isa_pkg::instr_u iread_data,
	output cpu_core_pkg::fetch_ctrl_t fetch,
	output cpu_core_pkg::exec_ctrl_t exec,
	output cpu_isa_pkg::instr_u inst,
	output logic trap
);
	import cpu_isa_pkg::*;
	import cpu_core_pkg::*;

	localparam flags_t ALL_FLAGS = '{c: 1'b1, z: 1'b1, n: 1'b1};
	localparam flags_t ZN_FLAGS = '{c: 1'b0, z: 1'b1, n: 1'b1};

	// second stage holds NOP out of reset
	always_ff @(posedge clk)
	begin
		if (reset)
			inst.wide <= '{imm16: 16'h0000, opcode: OP_NOP};
		else
			inst <= iread_data;
	end

	// length, jump and read decisions for the fetched word
	always_comb
	begin
		fetch = '{length: 2'd1, jump: JMP_NONE, read_mode: MEM_NONE};
		case (iread_data.wide.opcode)
			OP_LD_XL_IMM, OP_ADD_XL_IMM, OP_SUB_XL_IMM,
			OP_AND_XL_IMM, OP_OR_XL_IMM, OP_XOR_XL_IMM:
				fetch.length = 2'd2;
			OP_LD_XL_DIR:
			begin
				fetch.length = 2'd3;
				fetch.read_mode = MEM_DIR;
			end
			OP_LD_XL_ZREL:
			begin
				fetch.length = 2'd3;
				fetch.read_mode = MEM_ZREL;
			end
			OP_LD_DIR_XL, OP_LD_ZREL_XL, OP_LDW_Y_IMM, OP_ADDW_Y_IMM, OP_LDW_DIR_Y:
				fetch.length = 2'd3;
			OP_JP_IMM:
			begin
				fetch.length = 2'd3;
				fetch.jump = JMP_ABS;
			end
			OP_JR_D:
			begin
				fetch.length = 2'd2;
				fetch.jump = JMP_REL;
			end
			OP_JRZ_D:
			begin
				fetch.length = 2'd2;
				fetch.jump = JMP_REL_Z;
			end
			OP_JRNZ_D:
			begin
				fetch.length = 2'd2;
				fetch.jump = JMP_REL_NZ;
			end
			OP_JRC_D:
			begin
				fetch.length = 2'd2;
				fetch.jump = JMP_REL_C;
			end
			OP_JRNC_D:
			begin
				fetch.length = 2'd2;
				fetch.jump = JMP_REL_NC;
			end
			default:
				;
		endcase
	end

	// datapath control for the executing word
	always_comb
	begin
		exec = '{alu_op: PASS8, a_src: A_XL, reg_sel: REG_X, reg_en: 2'b00,
			write_mode: MEM_NONE, write_en: 2'b00, flag_mask: 3'b000, trap: 1'b0};
		case (inst.wide.opcode)
			OP_TRAP:
				exec.trap = 1'b1;
			OP_LD_XL_IMM:
			begin
				exec.a_src = A_IMM;
				exec.reg_en = 2'b01;
			end
			OP_ADD_XL_IMM, OP_SUB_XL_IMM:
			begin
				exec.alu_op = (inst.wide.opcode == OP_ADD_XL_IMM) ? ADD8 : SUB8;
				exec.reg_en = 2'b01;
				exec.flag_mask = ALL_FLAGS;
			end
			OP_AND_XL_IMM, OP_OR_XL_IMM, OP_XOR_XL_IMM:
			begin
				exec.alu_op = (inst.wide.opcode == OP_AND_XL_IMM) ? AND8 :
					(inst.wide.opcode == OP_OR_XL_IMM) ? OR8 : XOR8;
				exec.reg_en = 2'b01;
				exec.flag_mask = ZN_FLAGS;
			end
			OP_LD_XL_DIR, OP_LD_XL_ZREL:
			begin
				exec.a_src = A_MEM;
				exec.reg_en = 2'b01;
			end
			OP_LD_DIR_XL, OP_LD_ZREL_XL:
			begin
				exec.write_mode = (inst.wide.opcode == OP_LD_DIR_XL) ? MEM_DIR : MEM_ZREL;
				exec.write_en = 2'b01;
			end
			OP_LDW_Y_IMM:
			begin
				exec.alu_op = PASS16;
				exec.a_src = A_IMM;
				exec.reg_sel = REG_Y;
				exec.reg_en = 2'b11;
			end
			OP_ADDW_Y_IMM:
			begin
				exec.alu_op = ADD16;
				exec.a_src = A_Y;
				exec.reg_sel = REG_Y;
				exec.reg_en = 2'b11;
				exec.flag_mask = ALL_FLAGS;
			end
			OP_LDW_Z_Y:
			begin
				exec.alu_op = PASS16;
				exec.a_src = A_Y;
				exec.reg_sel = REG_Z;
				exec.reg_en = 2'b11;
			end
			OP_LDW_DIR_Y:
			begin
				exec.alu_op = PASS16;
				exec.a_src = A_Y;
				exec.write_mode = MEM_DIR;
				exec.write_en = 2'b11;
			end
			default:
				;
		endcase
	end

	assign trap = exec.trap;

	// a trap never comes with a data write
	assert property (@(posedge clk) disable iff (reset)
		trap |-> exec.write_en == 2'b00);

endmodule

`default_nettype wire

/* rtl/cpu_core_pkg.sv */
`default_nettype none

package cpu_core_pkg;

	parameter logic [15:0] RESET_PC_DEFAULT = 16'h4000;

	typedef struct packed {
		logic c;
		logic z;
		logic n;
	} flags_t;

	typedef enum logic [2:0] {
		JMP_NONE,
		JMP_ABS,
		JMP_REL,
		JMP_REL_Z,
		JMP_REL_NZ,
		JMP_REL_C,
		JMP_REL_NC
	} jump_kind_t;

	// shared by data reads and data writes
	typedef enum logic [1:0] {
		MEM_NONE,
		MEM_DIR,
		MEM_ZREL
	} mem_mode_t;

	typedef enum logic [1:0] {
		A_XL,
		A_Y,
		A_MEM,
		A_IMM
	} a_src_t;

	typedef struct packed {
		logic [1:0] length;
		jump_kind_t jump;
		mem_mode_t  read_mode;
	} fetch_ctrl_t;

	typedef struct packed {
		cpu_isa_pkg::alu_op_t  alu_op;
		a_src_t                a_src;
		cpu_isa_pkg::reg_sel_t reg_sel;
		logic [1:0]            reg_en;
		mem_mode_t             write_mode;
		logic [1:0]            write_en;
		flags_t                flag_mask;
		logic                  trap;
	} exec_ctrl_t;

	typedef struct packed {
		logic [15:0] addr;
		logic [15:0] data;
		logic [1:0]  en;
	} dwrite_t;

endpackage

`default_nettype wire

/* rtl/cpu_isa_pkg.sv */
`default_nettype none

package cpu_isa_pkg;

	// operand bytes follow the opcode, little-endian
	typedef enum logic [7:0] {
		OP_NOP        = 8'h00,
		OP_TRAP       = 8'h01,
		// xl with 8-bit immediate
		OP_LD_XL_IMM  = 8'h10,
		OP_ADD_XL_IMM = 8'h11,
		OP_SUB_XL_IMM = 8'h12,
		OP_AND_XL_IMM = 8'h13,
		OP_OR_XL_IMM  = 8'h14,
		OP_XOR_XL_IMM = 8'h15,
		// xl to and from memory, 16-bit address or z offset
		OP_LD_XL_DIR  = 8'h20,
		OP_LD_XL_ZREL = 8'h21,
		OP_LD_DIR_XL  = 8'h22,
		OP_LD_ZREL_XL = 8'h23,
		// 16-bit y and z
		OP_LDW_Y_IMM  = 8'h30,
		OP_ADDW_Y_IMM = 8'h31,
		OP_LDW_Z_Y    = 8'h32,
		OP_LDW_DIR_Y  = 8'h33,
		// jumps, relative ones take a signed byte
		OP_JP_IMM     = 8'h40,
		OP_JR_D       = 8'h41,
		OP_JRZ_D      = 8'h42,
		OP_JRNZ_D     = 8'h43,
		OP_JRC_D      = 8'h44,
		OP_JRNC_D     = 8'h45
	} opcode_t;

	typedef struct packed {
		logic [15:0] imm16;
		opcode_t     opcode;
	} instr_wide_t;

	typedef struct packed {
		logic [7:0] unused;
		logic [7:0] imm8;
		opcode_t    opcode;
	} instr_narrow_t;

	// three fetched bytes, opcode always in the low byte
	typedef union packed {
		instr_wide_t   wide;
		instr_narrow_t narrow;
	} instr_u;

	typedef enum logic [2:0] {
		PASS8,
		ADD8,
		SUB8,
		AND8,
		OR8,
		XOR8,
		PASS16,
		ADD16
	} alu_op_t;

	typedef enum logic [1:0] {
		REG_X = 2'd0,
		REG_Y = 2'd1,
		REG_Z = 2'd2
	} reg_sel_t;

endpackage

`default_nettype wire
